// File: include/tester_defines.svh
`ifndef TESTER_DEFINES_SVH
`define TESTER_DEFINES_SVH

// bus widths
`define DATA_W        16
`define ADDR_W        22
`define CHAR_W        8

// consecutive tx_ready cycles before a byte goes out
`define READY_HOLD    8

// character codes
`define CHAR_CR       8'd13
`define CHAR_TAB      8'd9
`define CHAR_ZERO     8'h30
`define DIGIT_PREFIX  7'h18    // upper bits of "0" and "1"
`define OPT_WRITE     8'h31
`define OPT_READ      8'h32

// message text
`define MSG_LEN_W         5
`define MENU_LEN          27
`define WRITE_PROMPT_LEN  19
`define ADDR_PROMPT_LEN   16
`define WRITE_DONE_LEN    16
`define READ_PROMPT_LEN   21
`define READ_PREFIX_LEN   12
`define END_LEN           2

`endif

// File: hdl/tester_pkg.sv
`default_nettype none

`include "tester_defines.svh"

package tester_pkg;

  // fixed texts held in the message store
  typedef enum logic [2:0] {
    msg_menu,
    msg_write_prompt,
    msg_addr_prompt,
    msg_write_done,
    msg_read_prompt,
    msg_read_prefix,
    msg_crlf_end
  } msg_id_t;

  typedef struct packed {
    logic [`CHAR_W-2:0] prefix;  // matches DIGIT_PREFIX for "0"/"1"
    logic               value;   // the digit itself
  } digit_char_t;

  // received byte, taken whole or split as a binary digit
  typedef union packed {
    logic [`CHAR_W-1:0] raw;
    digit_char_t        digit;
  } rx_char_t;

  typedef enum logic [3:0] {
    st_menu,
    st_wait_opt,
    st_write_prompt,
    st_data_entry,
    st_addr_prompt,
    st_addr_entry,
    st_write_req,
    st_write_wait,
    st_write_done,
    st_read_prompt,
    st_read_entry,
    st_read_req,
    st_read_wait,
    st_read_prefix,
    st_read_digits,
    st_read_end
  } seq_state_t;

endpackage

`default_nettype wire

// File: hdl/tx_pacer.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module tx_pacer (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 byte_valid,
  input  wire  [`CHAR_W-1:0]  byte_data,
  input  wire                 tx_ready,
  output logic                byte_taken,
  output logic                tx_start,
  output logic [`CHAR_W-1:0]  w_data
);

  localparam int CNT_W = $clog2(`READY_HOLD);
  localparam logic [CNT_W-1:0] HOLD_LAST = CNT_W'(`READY_HOLD - 1);

  logic [CNT_W-1:0] ready_cnt;  // cycles of tx_ready seen in a row
  logic             fire;

  // last cycle of the hold window with a byte waiting
  assign fire = byte_valid && tx_ready && (ready_cnt == HOLD_LAST);

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      ready_cnt <= '0;
      tx_start  <= 1'b0;
    end
    else
    begin
      tx_start <= fire;
      if (!tx_ready || fire)
        ready_cnt <= '0;  // a low cycle or a send restarts the window
      else if (ready_cnt != HOLD_LAST)
        ready_cnt <= ready_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fire)
      w_data <= byte_data;
  end

  assign byte_taken = tx_start;  // source may advance now

  // tx_ready high at both ends of the hold window before a launch
  a_start_after_hold: assert property (@(posedge clk) disable iff (reset)
    tx_start |-> $past(tx_ready) && $past(tx_ready, `READY_HOLD));

endmodule

`default_nettype wire

// File: hdl/message_rom.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module message_rom (
  input  wire tester_pkg::msg_id_t   msg,
  input  wire  [`MSG_LEN_W-1:0]      index,
  output logic [`CHAR_W-1:0]         char_out,
  output logic                       last
);
  import tester_pkg::*;

  localparam int TXT_W = (1 << `MSG_LEN_W) * `CHAR_W;

  //////////////////////////////////////////////////////////////////////
  // message texts, first character in the top byte
  //////////////////////////////////////////////////////////////////////

  localparam logic [TXT_W-1:0] MENU_TXT = {
    `CHAR_CR, "1-Write", `CHAR_TAB,
    `CHAR_CR, "2-Read", `CHAR_TAB,
    `CHAR_CR, "Options:", `CHAR_CR
  };
  localparam logic [TXT_W-1:0] WRITE_PROMPT_TXT = {
    `CHAR_CR, "WRITE", `CHAR_CR, "-Enter data:"
  };
  localparam logic [TXT_W-1:0] ADDR_PROMPT_TXT = {
    `CHAR_CR, "-Enter address:"
  };
  localparam logic [TXT_W-1:0] WRITE_DONE_TXT = {
    `CHAR_CR, "Data written!", `CHAR_CR, `CHAR_CR
  };
  localparam logic [TXT_W-1:0] READ_PROMPT_TXT = {
    `CHAR_CR, "READ", `CHAR_CR, "-Enter address:"
  };
  localparam logic [TXT_W-1:0] READ_PREFIX_TXT = {
    `CHAR_CR, "Read data: "
  };
  localparam logic [TXT_W-1:0] END_TXT = {`CHAR_CR, `CHAR_CR};

  logic [TXT_W-1:0] txt;
  int               len;

  always_comb
  begin
    case (msg)
      msg_menu:
      begin
        txt = MENU_TXT;
        len = `MENU_LEN;
      end
      msg_write_prompt:
      begin
        txt = WRITE_PROMPT_TXT;
        len = `WRITE_PROMPT_LEN;
      end
      msg_addr_prompt:
      begin
        txt = ADDR_PROMPT_TXT;
        len = `ADDR_PROMPT_LEN;
      end
      msg_write_done:
      begin
        txt = WRITE_DONE_TXT;
        len = `WRITE_DONE_LEN;
      end
      msg_read_prompt:
      begin
        txt = READ_PROMPT_TXT;
        len = `READ_PROMPT_LEN;
      end
      msg_read_prefix:
      begin
        txt = READ_PREFIX_TXT;
        len = `READ_PREFIX_LEN;
      end
      default:
      begin
        txt = END_TXT;
        len = `END_LEN;
      end
    endcase

    // texts are right aligned, so position 0 sits len-1 bytes up
    char_out = txt[(len - 1 - int'(index)) * `CHAR_W +: `CHAR_W];
    last     = (int'(index) == len - 1);
  end

endmodule

`default_nettype wire

// File: hdl/binary_entry.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module binary_entry #(
  parameter int DIGITS = 16
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire                 enable,
  input  wire                 rx_done_tick,
  input  wire  [`CHAR_W-1:0]  r_data,
  output logic [DIGITS-1:0]   word,
  output logic                echo_valid,
  input  wire                 echo_taken,
  output logic                done
);
  import tester_pkg::*;

  localparam int CNT_W = $clog2(DIGITS);
  localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(DIGITS - 1);

  rx_char_t         rx_ch;
  logic [CNT_W-1:0] count;  // digits taken so far
  logic             accept;

  assign rx_ch.raw = r_data;

  // only "0" or "1", and never over a pending echo
  assign accept = enable && rx_done_tick && !echo_valid &&
                  (rx_ch.digit.prefix == `DIGIT_PREFIX);

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      count      <= '0;
      echo_valid <= 1'b0;
      done       <= 1'b0;
    end
    else if (accept)
    begin
      echo_valid <= 1'b1;
      done       <= (count == LAST_CNT);
      count      <= (count == LAST_CNT) ? '0 : count + 1'b1;
    end
    else if (echo_taken)
    begin
      echo_valid <= 1'b0;
      done       <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      word <= {word[DIGITS-2:0], rx_ch.digit.value};  // msb first
  end

  a_count_range: assert property (@(posedge clk) disable iff (reset)
    count < DIGITS);

endmodule

`default_nettype wire

// File: hdl/menu_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module menu_sequencer (
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    rx_done_tick,
  input  wire  [`CHAR_W-1:0]     r_data,
  output tester_pkg::msg_id_t    msg,
  output logic [`MSG_LEN_W-1:0]  index,
  input  wire  [`CHAR_W-1:0]     rom_char,
  input  wire                    rom_last,
  output logic                   byte_valid,
  output logic [`CHAR_W-1:0]     byte_data,
  input  wire                    byte_taken,
  output logic                   data_enable,
  output logic                   addr_enable,
  input  wire                    data_echo_valid,
  input  wire                    addr_echo_valid,
  input  wire                    data_done,
  input  wire                    addr_done,
  output logic                   echo_taken,
  output logic                   write_go,
  output logic                   read_go,
  input  wire                    req_done,
  input  wire  [`DATA_W-1:0]     read_word
);
  import tester_pkg::*;

  localparam int BIT_W = $clog2(`DATA_W);
  localparam logic [`MSG_LEN_W-1:0] LAST_DIGIT = `MSG_LEN_W'(`DATA_W - 1);

  seq_state_t          state;
  seq_state_t          text_next;   // where a finished text leads
  logic                text_phase;
  logic                digit_phase;
  logic [`CHAR_W-1:0]  rx_hold;     // byte to echo
  logic [BIT_W-1:0]    bit_sel;
  logic [`CHAR_W-1:0]  digit_char;

  //////////////////////////////////////////////////////////////////////
  // message selection per state
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    text_phase = 1'b1;
    msg        = msg_menu;
    text_next  = st_wait_opt;
    case (state)
      st_menu:
        text_next = st_wait_opt;
      st_write_prompt:
      begin
        msg       = msg_write_prompt;
        text_next = st_data_entry;
      end
      st_addr_prompt:
      begin
        msg       = msg_addr_prompt;
        text_next = st_addr_entry;
      end
      st_write_done:
      begin
        msg       = msg_write_done;
        text_next = st_menu;
      end
      st_read_prompt:
      begin
        msg       = msg_read_prompt;
        text_next = st_read_entry;
      end
      st_read_prefix:
      begin
        msg       = msg_read_prefix;
        text_next = st_read_digits;
      end
      st_read_end:
      begin
        msg       = msg_crlf_end;
        text_next = st_wait_opt;  // read ends without the menu
      end
      default:
        text_phase = 1'b0;
    endcase
  end

  assign digit_phase = (state == st_read_digits);
  assign data_enable = (state == st_data_entry);
  assign addr_enable = (state == st_addr_entry) || (state == st_read_entry);
  assign write_go    = (state == st_write_req);
  assign read_go     = (state == st_read_req);
  assign echo_taken  = byte_taken && (data_enable || addr_enable);

  // read-back, msb first
  assign bit_sel    = BIT_W'(`DATA_W - 1) - index[BIT_W-1:0];
  assign digit_char = `CHAR_ZERO + {{(`CHAR_W-1){1'b0}}, read_word[bit_sel]};

  assign byte_valid = text_phase || digit_phase ||
                      (data_enable && data_echo_valid) ||
                      (addr_enable && addr_echo_valid);
  assign byte_data  = text_phase  ? rom_char :
                      digit_phase ? digit_char : rx_hold;

  // same condition under which a collector takes a byte
  always_ff @(posedge clk)
  begin
    if (rx_done_tick && !data_echo_valid && !addr_echo_valid)
      rx_hold <= r_data;
  end

  //////////////////////////////////////////////////////////////////////
  // state flow
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      state <= st_menu;
      index <= '0;
    end
    else
    begin
      case (state)
        st_wait_opt:
          if (rx_done_tick)
          begin
            if (r_data == `OPT_WRITE)
              state <= st_write_prompt;
            else if (r_data == `OPT_READ)
              state <= st_read_prompt;  // anything else is dropped
          end
        st_data_entry:
          if (byte_taken && data_done)
            state <= st_addr_prompt;
        st_addr_entry:
          if (byte_taken && addr_done)
            state <= st_write_req;
        st_read_entry:
          if (byte_taken && addr_done)
            state <= st_read_req;
        st_write_req:
          state <= st_write_wait;
        st_write_wait:
          if (req_done)
            state <= st_write_done;
        st_read_req:
          state <= st_read_wait;
        st_read_wait:
          if (req_done)
            state <= st_read_prefix;
        st_read_digits:
          if (byte_taken)
          begin
            if (index == LAST_DIGIT)
            begin
              index <= '0;
              state <= st_read_end;
            end
            else
              index <= index + 1'b1;
          end
        default:
          if (byte_taken)  // text states
          begin
            if (rom_last)
            begin
              index <= '0;
              state <= text_next;
            end
            else
              index <= index + 1'b1;
          end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hdl/memory_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module memory_port (
  input  wire                clk,
  input  wire                reset,
  input  wire                write_go,
  input  wire                read_go,
  input  wire  [`ADDR_W-1:0] addr_word,
  input  wire  [`DATA_W-1:0] data_word,
  input  wire                sys_ack,
  output logic [`ADDR_W-1:0] sys_addr,
  output logic [`DATA_W-1:0] sys_data_to_sdram,
  input  wire  [`DATA_W-1:0] sys_data_from_sdram,
  output logic               sys_write_rq,
  output logic               sys_read_rq,
  output logic               req_done,
  output logic [`DATA_W-1:0] read_word
);

  logic busy;

  assign busy = sys_write_rq || sys_read_rq;

  always_ff @(posedge clk, posedge reset)
  begin
    if (reset)
    begin
      sys_write_rq <= 1'b0;
      sys_read_rq  <= 1'b0;
      req_done     <= 1'b0;
    end
    else
    begin
      req_done <= busy && sys_ack;
      if (busy && sys_ack)
      begin
        sys_write_rq <= 1'b0;  // drop the cycle after ack
        sys_read_rq  <= 1'b0;
      end
      else if (!busy)
      begin
        sys_write_rq <= write_go;
        sys_read_rq  <= read_go;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sys_read_rq && sys_ack)
      read_word <= sys_data_from_sdram;
  end

  // collectors hold their words while the request is open
  assign sys_addr          = busy ? addr_word : '0;
  assign sys_data_to_sdram = data_word;

  a_one_request: assert property (@(posedge clk) disable iff (reset)
    !(sys_write_rq && sys_read_rq));

  // an open request keeps its kind and address until acknowledged
  a_request_held: assert property (@(posedge clk) disable iff (reset)
    busy && !sys_ack |=> $stable({sys_write_rq, sys_read_rq, sys_addr}));

endmodule

`default_nettype wire

// File: hdl/sdram_uart_tester.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module sdram_uart_tester (
  input  wire                clk,
  input  wire                reset,
  input  wire                rx_done_tick,
  input  wire  [`CHAR_W-1:0] r_data,
  input  wire                tx_ready,
  output wire                tx_start,
  output wire  [`CHAR_W-1:0] w_data,
  output wire  [`ADDR_W-1:0] sys_addr,
  output wire  [`DATA_W-1:0] sys_data_to_sdram,
  input  wire  [`DATA_W-1:0] sys_data_from_sdram,
  output wire                sys_write_rq,
  output wire                sys_read_rq,
  input  wire                sys_ack
);
  import tester_pkg::*;

  msg_id_t               msg;
  wire [`MSG_LEN_W-1:0]  index;
  wire [`CHAR_W-1:0]     rom_char;
  wire                   rom_last;
  wire                   byte_valid;
  wire [`CHAR_W-1:0]     byte_data;
  wire                   byte_taken;
  wire                   data_enable;
  wire                   addr_enable;
  wire                   data_echo_valid;
  wire                   addr_echo_valid;
  wire                   data_done;
  wire                   addr_done;
  wire                   echo_taken;
  wire                   write_go;
  wire                   read_go;
  wire                   req_done;
  wire [`DATA_W-1:0]     read_word;
  wire [`DATA_W-1:0]     data_word;
  wire [`ADDR_W-1:0]     addr_word;

  menu_sequencer u_sequencer (
    .clk             (clk),
    .reset           (reset),
    .rx_done_tick    (rx_done_tick),
    .r_data          (r_data),
    .msg             (msg),
    .index           (index),
    .rom_char        (rom_char),
    .rom_last        (rom_last),
    .byte_valid      (byte_valid),
    .byte_data       (byte_data),
    .byte_taken      (byte_taken),
    .data_enable     (data_enable),
    .addr_enable     (addr_enable),
    .data_echo_valid (data_echo_valid),
    .addr_echo_valid (addr_echo_valid),
    .data_done       (data_done),
    .addr_done       (addr_done),
    .echo_taken      (echo_taken),
    .write_go        (write_go),
    .read_go         (read_go),
    .req_done        (req_done),
    .read_word       (read_word)
  );

  tx_pacer u_pacer (
    .clk        (clk),
    .reset      (reset),
    .byte_valid (byte_valid),
    .byte_data  (byte_data),
    .tx_ready   (tx_ready),
    .byte_taken (byte_taken),
    .tx_start   (tx_start),
    .w_data     (w_data)
  );

  message_rom u_rom (
    .msg      (msg),
    .index    (index),
    .char_out (rom_char),
    .last     (rom_last)
  );

  //////////////////////////////////////////////////////////////////////
  // digit collectors, one per entry field
  //////////////////////////////////////////////////////////////////////

  binary_entry #(.DIGITS(`DATA_W)) data_entry (
    .clk          (clk),
    .reset        (reset),
    .enable       (data_enable),
    .rx_done_tick (rx_done_tick),
    .r_data       (r_data),
    .word         (data_word),
    .echo_valid   (data_echo_valid),
    .echo_taken   (echo_taken),
    .done         (data_done)
  );

  binary_entry #(.DIGITS(`ADDR_W)) addr_entry (
    .clk          (clk),
    .reset        (reset),
    .enable       (addr_enable),
    .rx_done_tick (rx_done_tick),
    .r_data       (r_data),
    .word         (addr_word),
    .echo_valid   (addr_echo_valid),
    .echo_taken   (echo_taken),
    .done         (addr_done)
  );

  memory_port u_mem_port (
    .clk                 (clk),
    .reset               (reset),
    .write_go            (write_go),
    .read_go             (read_go),
    .addr_word           (addr_word),
    .data_word           (data_word),
    .sys_ack             (sys_ack),
    .sys_addr            (sys_addr),
    .sys_data_to_sdram   (sys_data_to_sdram),
    .sys_data_from_sdram (sys_data_from_sdram),
    .sys_write_rq        (sys_write_rq),
    .sys_read_rq         (sys_read_rq),
    .req_done            (req_done),
    .read_word           (read_word)
  );

endmodule

`default_nettype wire

// File: verification/sdram_model.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module sdram_model (
  input  wire                clk,
  input  wire                reset,
  input  wire  [`ADDR_W-1:0] sys_addr,
  input  wire  [`DATA_W-1:0] sys_data_to_sdram,
  output wire  [`DATA_W-1:0] sys_data_from_sdram,
  input  wire                sys_write_rq,
  input  wire                sys_read_rq,
  output wire                sys_ack,
  input  wire  [4:0]         ack_delay
);

  logic [`DATA_W-1:0] mem [logic [`ADDR_W-1:0]];  // sparse storage
  logic               ack_q   = 1'b0;
  logic [`DATA_W-1:0] rdata_q = '0;
  int                 wait_cnt = 0;

  assign sys_ack             = ack_q;
  assign sys_data_from_sdram = rdata_q;

  // unwritten words, every address bit takes part
  function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] a);
    return a[15:0] ^ {a[21:16], a[21:12]};
  endfunction

  // answers on the falling edge so the DUT sees settled values
  always @(negedge clk, posedge reset)
  begin
    if (reset)
    begin
      ack_q    = 1'b0;
      rdata_q  = '0;
      wait_cnt = 0;
    end
    else if (ack_q)
      ack_q = 1'b0;  // single cycle ack
    else if (sys_write_rq || sys_read_rq)
    begin
      if (wait_cnt < int'(ack_delay))
        wait_cnt = wait_cnt + 1;
      else
      begin
        wait_cnt = 0;
        ack_q    = 1'b1;
        if (sys_write_rq)
          mem[sys_addr] = sys_data_to_sdram;
        else
          rdata_q = mem.exists(sys_addr) ? mem[sys_addr] : fill_word(sys_addr);
      end
    end
    else
      wait_cnt = 0;
  end

endmodule

`default_nettype wire

// File: verification/sdram_uart_tester_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "tester_defines.svh"

module sdram_uart_tester_tb;

  localparam int RX_GAP         = 40;  // cycles between received bytes
  localparam int SETTLE         = 60;  // quiet window before a text compare
  localparam int MAX_ACK        = 20;
  localparam int TX_BYTE_CYCLES = 15 + `READY_HOLD + 2;
  localparam int TX_BYTES       = 478;  // every expected output character
  localparam int RX_BYTES       = 174;  // options, digits, noise letters
  localparam int TEXT_CHECKS    = 7;
  localparam int WATCHDOG_CYCLES = 2 * (TX_BYTES * TX_BYTE_CYCLES + RX_BYTES * RX_GAP +
                                        TEXT_CHECKS * SETTLE + 5 * (MAX_ACK + 2));

  logic               clk;
  logic               reset;
  logic               rx_done_tick;
  logic [`CHAR_W-1:0] r_data;
  logic               tx_ready;
  logic [4:0]         ack_delay;
  wire                tx_start;
  wire  [`CHAR_W-1:0] w_data;
  wire  [`ADDR_W-1:0] sys_addr;
  wire  [`DATA_W-1:0] sys_data_to_sdram;
  wire  [`DATA_W-1:0] sys_data_from_sdram;
  wire                sys_write_rq;
  wire                sys_read_rq;
  wire                sys_ack;

  logic [31:0]        lfsr = 32'h1f77;
  int                 ready_gap = 0;
  string              captured_text = "";
  string              expected_text = "";
  logic               text_check = 1'b0;
  logic               idle_phase = 1'b0;  // no memory traffic allowed
  logic [`ADDR_W-1:0] exp_addr = '0;
  logic [`DATA_W-1:0] exp_data = '0;
  int                 error_count = 0;
  int                 errors_at_start = 0;
  int                 test_num = 0;
  int                 tests_with_errors = 0;
  string              cr;
  string              tab;
  string              menu_txt;
  string              write_prompt_txt;
  string              addr_prompt_txt;
  string              write_done_txt;
  string              read_prompt_txt;
  string              read_prefix_txt;
  string              end_txt;

  sdram_uart_tester uut (
    .clk                 (clk),
    .reset               (reset),
    .rx_done_tick        (rx_done_tick),
    .r_data              (r_data),
    .tx_ready            (tx_ready),
    .tx_start            (tx_start),
    .w_data              (w_data),
    .sys_addr            (sys_addr),
    .sys_data_to_sdram   (sys_data_to_sdram),
    .sys_data_from_sdram (sys_data_from_sdram),
    .sys_write_rq        (sys_write_rq),
    .sys_read_rq         (sys_read_rq),
    .sys_ack             (sys_ack)
  );

  sdram_model u_sdram (
    .clk                 (clk),
    .reset               (reset),
    .sys_addr            (sys_addr),
    .sys_data_to_sdram   (sys_data_to_sdram),
    .sys_data_from_sdram (sys_data_from_sdram),
    .sys_write_rq        (sys_write_rq),
    .sys_read_rq         (sys_read_rq),
    .sys_ack             (sys_ack),
    .ack_delay           (ack_delay)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  function automatic string bits_text(input logic [31:0] value, input int width);
    string s;
    s = "";
    for (int i = width - 1; i >= 0; i--)
      s = $sformatf("%s%b", s, value[i]);
    return s;
  endfunction

  // control characters spelled out for the log
  function automatic string visible(input string s);
    string r;
    r = "";
    for (int i = 0; i < s.len(); i++)
    begin
      if (s[i] == 8'd13)
        r = {r, "<CR>"};
      else if (s[i] == 8'd9)
        r = {r, "<TAB>"};
      else
        r = {r, s.substr(i, i)};
    end
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////
  // uart host side
  ////////////////////////////////////////////////////////////////////////

  always @(negedge clk)
  begin
    if (tx_start)
    begin
      captured_text = $sformatf("%s%c", captured_text, w_data);
      ready_gap     = 1 + take_bits(4) % 15;
      tx_ready      = 1'b0;  // transmitter busy
    end
    else if (ready_gap > 1)
      ready_gap = ready_gap - 1;
    else if (ready_gap == 1)
    begin
      ready_gap = 0;
      tx_ready  = 1'b1;
    end
  end

  task automatic send_byte(input logic [`CHAR_W-1:0] b);
    @(negedge clk);
    r_data       = b;
    rx_done_tick = 1'b1;
    @(negedge clk);
    rx_done_tick = 1'b0;
    repeat (RX_GAP - 1) @(negedge clk);
  endtask

  task automatic send_digits(input logic [31:0] value, input int width);
    int letters;
    letters = 0;
    for (int i = width - 1; i >= 0; i--)
    begin
      send_byte(`CHAR_ZERO + {7'd0, value[i]});
      if (i % 5 == 3)
      begin
        send_byte(8'h61 + 8'(letters));  // noise, never echoed
        letters++;
      end
    end
  endtask

  task automatic wait_len(input int n);
    while (captured_text.len() < n)
      @(negedge clk);
  endtask

  task automatic check_text(input string exp);
    repeat (SETTLE) @(negedge clk);  // lets any stray byte show up
    expected_text = exp;
    text_check    = 1'b1;
    @(negedge clk);
    text_check    = 1'b0;
  endtask

  task automatic begin_test();
    test_num++;
    errors_at_start = error_count;
    captured_text   = "";
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_count - errors_at_start;
    if (errs != 0)
      tests_with_errors++;
    $display("test %0d (%s) finished with %0d errors", test_num, name, errs);
  endtask

  task automatic run_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    string exp;
    exp_addr      = addr;
    exp_data      = data;
    captured_text = "";
    exp = {write_prompt_txt, bits_text(data, `DATA_W), addr_prompt_txt,
           bits_text(addr, `ADDR_W), write_done_txt, menu_txt};
    send_byte(`OPT_WRITE);
    wait_len(write_prompt_txt.len());
    send_digits(data, `DATA_W);
    wait_len(write_prompt_txt.len() + `DATA_W + addr_prompt_txt.len());
    send_digits(addr, `ADDR_W);
    wait_len(exp.len());
    check_text(exp);
  endtask

  task automatic run_read(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
    string exp;
    exp_addr      = addr;
    captured_text = "";
    exp = {read_prompt_txt, bits_text(addr, `ADDR_W), read_prefix_txt,
           bits_text(data, `DATA_W), end_txt};
    send_byte(`OPT_READ);
    wait_len(read_prompt_txt.len());
    send_digits(addr, `ADDR_W);
    wait_len(exp.len());
    check_text(exp);
  endtask

  ////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////

  a_capture_text: assert property (@(posedge clk) text_check |-> captured_text == expected_text)
  else
  begin
    error_count++;
    $display("Mismatch at %0t: captured_text expected \"%s\" actual \"%s\"", $time,
             visible(expected_text), visible(captured_text));
  end

  a_no_request: assert property (@(posedge clk) disable iff (reset)
    idle_phase |-> !sys_write_rq && !sys_read_rq)
  else
  begin
    error_count++;
    $display("At %0t a memory request was raised while the tester should be idle", $time);
  end

  a_write_addr: assert property (@(posedge clk) disable iff (reset)
    $rose(sys_write_rq) |-> sys_addr == exp_addr)
  else
  begin
    error_count++;
    $display("Mismatch at %0t: sys_addr expected %h actual %h", $time, exp_addr,
             $sampled(sys_addr));
  end

  a_write_data: assert property (@(posedge clk) disable iff (reset)
    $rose(sys_write_rq) |-> sys_data_to_sdram == exp_data)
  else
  begin
    error_count++;
    $display("Mismatch at %0t: sys_data_to_sdram expected %h actual %h", $time, exp_data,
             $sampled(sys_data_to_sdram));
  end

  a_read_addr: assert property (@(posedge clk) disable iff (reset)
    $rose(sys_read_rq) |-> sys_addr == exp_addr)
  else
  begin
    error_count++;
    $display("Mismatch at %0t: sys_addr expected %h actual %h", $time, exp_addr,
             $sampled(sys_addr));
  end

  // request must wait for its ack without moving
  a_request_held: assert property (@(posedge clk) disable iff (reset)
    (sys_write_rq || sys_read_rq) && !sys_ack |=>
      (sys_write_rq || sys_read_rq) && $stable(sys_addr))
  else
  begin
    error_count++;
    $display("At %0t a memory request dropped or changed its address before sys_ack", $time);
  end

  ////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [`DATA_W-1:0] data_a;
    logic [`ADDR_W-1:0] addr_a;
    logic [`DATA_W-1:0] data_b;
    logic [`ADDR_W-1:0] addr_b;

    reset        = 1'b1;
    rx_done_tick = 1'b0;
    r_data       = '0;
    tx_ready     = 1'b1;
    ack_delay    = '0;

    cr               = "\015";
    tab              = "\011";
    menu_txt         = {cr, "1-Write", tab, cr, "2-Read", tab, cr, "Options:", cr};
    write_prompt_txt = {cr, "WRITE", cr, "-Enter data:"};
    addr_prompt_txt  = {cr, "-Enter address:"};
    write_done_txt   = {cr, "Data written!", cr, cr};
    read_prompt_txt  = {cr, "READ", cr, "-Enter address:"};
    read_prefix_txt  = {cr, "Read data: "};
    end_txt          = {cr, cr};

    // menu straight out of reset
    begin_test();
    idle_phase = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    wait_len(menu_txt.len());
    check_text(menu_txt);
    idle_phase = 1'b0;
    end_test("menu after reset");

    begin_test();
    ack_delay = 5'(take_bits(3));
    data_a    = `DATA_W'(take_bits(`DATA_W));
    addr_a    = `ADDR_W'(take_bits(`ADDR_W));
    run_write(addr_a, data_a);
    end_test("write with noise letters");

    begin_test();
    ack_delay = 5'(take_bits(3));
    run_read(addr_a, data_a);
    end_test("read back");

    begin_test();
    idle_phase = 1'b1;
    send_byte("7");
    check_text("");  // invalid option stays silent
    idle_phase = 1'b0;
    run_read(addr_a, data_a);
    end_test("invalid option then read");

    begin_test();
    ack_delay = 5'(MAX_ACK);
    data_b    = `DATA_W'(take_bits(`DATA_W));
    addr_b    = `ADDR_W'(take_bits(`ADDR_W));
    run_write(addr_b, data_b);
    run_read(addr_b, data_b);
    end_test("slow memory ack");

    $display("summary: %0d tests, %0d with errors, %0d check errors in total",
             test_num, tests_with_errors, error_count);
    if (error_count == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the DUT made no further progress after %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sdram_uart_tester.f
+incdir+include
hdl/tester_pkg.sv
hdl/tx_pacer.sv
hdl/message_rom.sv
hdl/binary_entry.sv
hdl/menu_sequencer.sv
hdl/memory_port.sv
hdl/sdram_uart_tester.sv
verification/sdram_model.sv
verification/sdram_uart_tester_tb.sv

// File: Makefile
SIM       = verilator
FLAGS     = --binary --assert --timing -Wno-fatal -j 0
TOP       = sdram_uart_tester_tb
FILELIST  = sdram_uart_tester.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG) || ! grep -q "Test completed successfully" $(LOG); \
	then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
